//--- dcache_pkg.sv
package dcache_pkg;

   // request and line geometry
   localparam int ADDR_BITS   = 32;
   localparam int WORD_BITS   = 32;
   localparam int WORD_BYTES  = WORD_BITS / 8;
   localparam int LINE_WORDS  = 16;
   localparam int LINE_BYTES  = LINE_WORDS * WORD_BYTES;
   localparam int NUM_WAYS    = 2;
   localparam int CACHE_BYTES = 4096;

   // derived address split
   localparam int NUM_SETS      = CACHE_BYTES / NUM_WAYS / LINE_BYTES;
   localparam int OFFSET_BITS   = $clog2(LINE_BYTES);
   localparam int WORD_SEL_BITS = $clog2(LINE_WORDS);
   localparam int INDEX_BITS    = $clog2(NUM_SETS);
   localparam int TAG_BITS      = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

   // refill counter must reach LINE_WORDS itself
   localparam int COUNT_BITS = $clog2(LINE_WORDS + 1);

   // controller states
   localparam logic [1:0] ST_IDLE       = 2'd0;
   localparam logic [1:0] ST_LOOKUP     = 2'd1;
   localparam logic [1:0] ST_WRITE_BACK = 2'd2;
   localparam logic [1:0] ST_REFILL     = 2'd3;

   // one line seen flat or as words
   // word 0 sits at the low end
   typedef union packed {
      logic [LINE_WORDS*WORD_BITS-1:0]      flat;
      logic [LINE_WORDS-1:0][WORD_BITS-1:0] words;
   } cache_line_t;

endpackage

//--- tag_store.sv
`timescale 1ns/1ps

module tag_store (
   input  logic                                                      clk,
   input  logic                                                      reset,
   input  logic [dcache_pkg::INDEX_BITS-1:0]                         rd_index,
   input  logic [dcache_pkg::INDEX_BITS-1:0]                         wr_index,
   input  logic [dcache_pkg::TAG_BITS-1:0]                           tag_in,
   input  logic [dcache_pkg::NUM_WAYS-1:0]                           way_we,
   input  logic [dcache_pkg::TAG_BITS-1:0]                           new_tag,
   input  logic                                                      new_dirty,
   input  logic                                                      lru_we,
   input  logic                                                      new_lru,
   output logic [dcache_pkg::NUM_WAYS-1:0]                           way_hit,
   output logic [dcache_pkg::NUM_WAYS-1:0]                           way_dirty,
   output logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::TAG_BITS-1:0] way_tag,
   output logic                                                      lru
);
   import dcache_pkg::*;

   logic [TAG_BITS-1:0] tag_mem [NUM_WAYS][NUM_SETS];
   logic [NUM_SETS-1:0] valid_bits [NUM_WAYS];
   logic [NUM_SETS-1:0] dirty_bits [NUM_WAYS];
   logic [NUM_SETS-1:0] lru_bits;
   logic [NUM_WAYS-1:0] valid_q;

   // tag array with registered read
   always_ff @(posedge clk) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (way_we[w]) begin
            tag_mem[w][wr_index] <= new_tag;
         end
         way_tag[w] <= tag_mem[w][rd_index];
      end
   end

   // valid, dirty and lru bits
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int w = 0; w < NUM_WAYS; w++) begin
            valid_bits[w] <= '0;
            dirty_bits[w] <= '0;
         end
         lru_bits  <= '0;
         valid_q   <= '0;
         way_dirty <= '0;
         lru       <= 1'b0;
      end else begin
         for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_we[w]) begin
               valid_bits[w][wr_index] <= 1'b1;
               dirty_bits[w][wr_index] <= new_dirty;
            end
            valid_q[w]   <= valid_bits[w][rd_index];
            way_dirty[w] <= dirty_bits[w][rd_index];
         end
         if (lru_we) begin
            lru_bits[wr_index] <= new_lru;
         end
         lru <= lru_bits[rd_index];
      end
   end

   // compare against the set read last cycle
   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         way_hit[w] = valid_q[w] && (way_tag[w] == tag_in);
      end
   end

   // a line is never filled into a second way of its set
   a_single_hit: assert property (@(posedge clk) disable iff (reset)
      $onehot0(way_hit));

endmodule

//--- data_store.sv
`timescale 1ns/1ps

module data_store (
   input  logic                                               clk,
   input  logic [dcache_pkg::INDEX_BITS-1:0]                  rd_index,
   input  logic [dcache_pkg::INDEX_BITS-1:0]                  wr_index,
   input  logic [dcache_pkg::NUM_WAYS-1:0]                    way_we,
   input  dcache_pkg::cache_line_t                            wr_line,
   output dcache_pkg::cache_line_t [dcache_pkg::NUM_WAYS-1:0] way_line
);
   import dcache_pkg::*;

   cache_line_t line_mem [NUM_WAYS][NUM_SETS];

   // one line ram per way
   // a read in the write cycle returns the old line
   always_ff @(posedge clk) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (way_we[w]) begin
            line_mem[w][wr_index] <= wr_line;
         end
         way_line[w] <= line_mem[w][rd_index];
      end
   end

endmodule

//--- refill_buffer.sv
`timescale 1ns/1ps

module refill_buffer (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             refill_start,
   input  logic [dcache_pkg::WORD_BITS-1:0] mem_rdata,
   input  logic                             mem_rdata_valid,
   output dcache_pkg::cache_line_t          line,
   output logic                             line_done
);
   import dcache_pkg::*;

   logic [COUNT_BITS-1:0] count;
   logic                  take_word;

   assign line_done = (count == COUNT_BITS'(LINE_WORDS));
   assign take_word = mem_rdata_valid && !line_done && !refill_start;

   // words received in the current refill
   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else if (refill_start) begin
         count <= '0;
      end else if (take_word) begin
         count <= count + 1'b1;
      end
   end

   // new word enters at the top
   // after a full line word 0 has reached the bottom
   always_ff @(posedge clk) begin
      if (take_word) begin
         line.flat <= {mem_rdata, line.flat[LINE_WORDS*WORD_BITS-1:WORD_BITS]};
      end
   end

   a_count_range: assert property (@(posedge clk) disable iff (reset)
      count <= COUNT_BITS'(LINE_WORDS));

endmodule

//--- line_merge.sv
`timescale 1ns/1ps

module line_merge (
   input  dcache_pkg::cache_line_t              src_line,
   input  logic [dcache_pkg::WORD_SEL_BITS-1:0] word_sel,
   input  logic [dcache_pkg::WORD_BITS-1:0]     wdata,
   input  logic [dcache_pkg::WORD_BYTES-1:0]    wmask,
   input  logic                                 we,
   output dcache_pkg::cache_line_t              merged_line,
   output logic [dcache_pkg::WORD_BITS-1:0]     sel_word
);
   import dcache_pkg::*;

   logic [WORD_BITS-1:0] new_word;

   assign sel_word = src_line.words[word_sel];

   // only enabled bytes of the addressed word change
   always_comb begin
      new_word = sel_word;
      for (int b = 0; b < WORD_BYTES; b++) begin
         if (we && wmask[b]) begin
            new_word[b*8 +: 8] = wdata[b*8 +: 8];
         end
      end
      merged_line = src_line;
      merged_line.words[word_sel] = new_word;
   end

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
   input  logic                                                      clk,
   input  logic                                                      reset,
   input  logic                                                      ce,
   input  logic                                                      we,
   input  logic [dcache_pkg::ADDR_BITS-1:0]                          addr,
   input  logic                                                      resp_ready,
   input  logic [dcache_pkg::NUM_WAYS-1:0]                           way_hit,
   input  logic [dcache_pkg::NUM_WAYS-1:0]                           way_dirty,
   input  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::TAG_BITS-1:0] way_tag,
   input  logic                                                      lru,
   input  logic                                                      line_done,
   input  logic                                                      mem_write_resp,
   input  dcache_pkg::cache_line_t [dcache_pkg::NUM_WAYS-1:0]        way_line,
   input  dcache_pkg::cache_line_t                                   refill_line,
   input  logic [dcache_pkg::WORD_BITS-1:0]                          sel_word,
   output logic [dcache_pkg::INDEX_BITS-1:0]                         rd_index,
   output logic [dcache_pkg::INDEX_BITS-1:0]                         wr_index,
   output logic [dcache_pkg::WORD_SEL_BITS-1:0]                      word_sel,
   output logic [dcache_pkg::NUM_WAYS-1:0]                           way_we,
   output logic [dcache_pkg::TAG_BITS-1:0]                           new_tag,
   output logic                                                      new_dirty,
   output logic                                                      lru_we,
   output logic                                                      new_lru,
   output logic                                                      refill_start,
   output dcache_pkg::cache_line_t                                   src_line,
   output logic [dcache_pkg::WORD_BITS-1:0]                          rdata,
   output logic                                                      rdata_valid,
   output logic                                                      write_resp,
   output logic                                                      mem_ce,
   output logic                                                      mem_we,
   output logic [dcache_pkg::ADDR_BITS-1:0]                          mem_addr,
   output dcache_pkg::cache_line_t                                   mem_wdata
);
   import dcache_pkg::*;

   logic [1:0]            state;
   logic [1:0]            state_next;
   logic [TAG_BITS-1:0]   req_tag;
   logic [INDEX_BITS-1:0] req_index;
   logic                  lookup_hit;
   logic                  hit_way;
   logic                  target_way;
   logic                  victim_dirty;
   logic                  resp;
   logic                  resp_fire;

   // the processor holds addr until its response is taken
   assign req_tag   = addr[ADDR_BITS-1 -: TAG_BITS];
   assign req_index = addr[OFFSET_BITS +: INDEX_BITS];
   assign word_sel  = addr[OFFSET_BITS-1 -: WORD_SEL_BITS];

   assign lookup_hit   = (state == ST_LOOKUP) && (|way_hit);
   assign hit_way      = way_hit[1];
   assign victim_dirty = way_dirty[lru];
   // hit keeps its way and a miss replaces the lru way
   assign target_way   = lookup_hit ? hit_way : lru;

   always_comb begin
      state_next = state;
      case (state)
         ST_IDLE: begin
            if (ce) begin
               state_next = ST_LOOKUP;
            end
         end
         ST_LOOKUP: begin
            if (lookup_hit) begin
               if (resp_ready) begin
                  state_next = ST_IDLE;
               end
            end else if (victim_dirty) begin
               state_next = ST_WRITE_BACK;
            end else begin
               state_next = ST_REFILL;
            end
         end
         ST_WRITE_BACK: begin
            if (mem_write_resp) begin
               state_next = ST_REFILL;
            end
         end
         default: begin
            if (line_done && resp_ready) begin
               state_next = ST_IDLE;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_IDLE;
      end else begin
         state <= state_next;
      end
   end

   // restart the refill counter on the way into refill
   assign refill_start = ((state == ST_LOOKUP) && !(|way_hit) && !victim_dirty)
                       || ((state == ST_WRITE_BACK) && mem_write_resp);

   assign resp        = lookup_hit || ((state == ST_REFILL) && line_done);
   assign rdata_valid = resp && !we;
   assign write_resp  = resp && we;
   assign resp_fire   = resp && resp_ready;
   assign rdata       = sel_word;

   assign src_line = (state == ST_REFILL) ? refill_line : way_line[hit_way];

   // storage only changes when the response is taken
   assign rd_index  = req_index;
   assign wr_index  = req_index;
   assign new_tag   = req_tag;
   assign new_dirty = we || (lookup_hit && way_dirty[hit_way]);
   assign lru_we    = resp_fire;
   assign new_lru   = ~target_way;

   always_comb begin
      way_we = '0;
      way_we[target_way] = resp_fire;
   end

   // victim line and tag stay on the store outputs until the fill is written
   assign mem_ce    = (state == ST_WRITE_BACK) || ((state == ST_REFILL) && !line_done);
   assign mem_we    = (state == ST_WRITE_BACK);
   assign mem_wdata = way_line[lru];
   assign mem_addr  = (state == ST_WRITE_BACK)
                    ? {way_tag[lru], req_index, {OFFSET_BITS{1'b0}}}
                    : {req_tag, req_index, {OFFSET_BITS{1'b0}}};

   a_one_resp: assert property (@(posedge clk) disable iff (reset)
      !(rdata_valid && write_resp));

   a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
      (state == ST_IDLE) |-> !mem_ce);

   // word accesses only
   a_word_aligned: assert property (@(posedge clk) disable iff (reset)
      ce |-> (addr[$clog2(WORD_BYTES)-1:0] == '0));

endmodule

//--- dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                ce,
   input  logic                                we,
   input  logic [dcache_pkg::ADDR_BITS-1:0]    addr,
   input  logic [dcache_pkg::WORD_BITS-1:0]    wdata,
   input  logic [dcache_pkg::WORD_BYTES-1:0]   wmask,
   output logic [dcache_pkg::WORD_BITS-1:0]    rdata,
   output logic                                rdata_valid,
   output logic                                write_resp,
   input  logic                                resp_ready,
   output logic                                mem_ce,
   output logic                                mem_we,
   output logic [dcache_pkg::ADDR_BITS-1:0]    mem_addr,
   output dcache_pkg::cache_line_t             mem_wdata,
   input  logic [dcache_pkg::WORD_BITS-1:0]    mem_rdata,
   input  logic                                mem_rdata_valid,
   input  logic                                mem_write_resp
);
   import dcache_pkg::*;

   logic [INDEX_BITS-1:0]                rd_index;
   logic [INDEX_BITS-1:0]                wr_index;
   logic [WORD_SEL_BITS-1:0]             word_sel;
   logic [NUM_WAYS-1:0]                  way_we;
   logic [TAG_BITS-1:0]                  new_tag;
   logic                                 new_dirty;
   logic                                 lru_we;
   logic                                 new_lru;
   logic [NUM_WAYS-1:0]                  way_hit;
   logic [NUM_WAYS-1:0]                  way_dirty;
   logic [NUM_WAYS-1:0][TAG_BITS-1:0]    way_tag;
   logic                                 lru;
   cache_line_t [NUM_WAYS-1:0]           way_line;
   cache_line_t                          refill_line;
   logic                                 refill_start;
   logic                                 line_done;
   cache_line_t                          src_line;
   cache_line_t                          merged_line;
   logic [WORD_BITS-1:0]                 sel_word;

   dcache_ctrl u_ctrl (
      .clk(clk), .reset(reset),
      .ce(ce), .we(we), .addr(addr), .resp_ready(resp_ready),
      .way_hit(way_hit), .way_dirty(way_dirty), .way_tag(way_tag), .lru(lru),
      .line_done(line_done), .mem_write_resp(mem_write_resp),
      .way_line(way_line), .refill_line(refill_line), .sel_word(sel_word),
      .rd_index(rd_index), .wr_index(wr_index), .word_sel(word_sel),
      .way_we(way_we), .new_tag(new_tag), .new_dirty(new_dirty),
      .lru_we(lru_we), .new_lru(new_lru),
      .refill_start(refill_start), .src_line(src_line),
      .rdata(rdata), .rdata_valid(rdata_valid), .write_resp(write_resp),
      .mem_ce(mem_ce), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
   );

   // the request tag doubles as the tag written on a fill
   tag_store u_tag_store (
      .clk(clk), .reset(reset),
      .rd_index(rd_index), .wr_index(wr_index), .tag_in(new_tag),
      .way_we(way_we), .new_tag(new_tag), .new_dirty(new_dirty),
      .lru_we(lru_we), .new_lru(new_lru),
      .way_hit(way_hit), .way_dirty(way_dirty), .way_tag(way_tag), .lru(lru)
   );

   data_store u_data_store (
      .clk(clk),
      .rd_index(rd_index), .wr_index(wr_index),
      .way_we(way_we), .wr_line(merged_line),
      .way_line(way_line)
   );

   refill_buffer u_refill_buffer (
      .clk(clk), .reset(reset), .refill_start(refill_start),
      .mem_rdata(mem_rdata), .mem_rdata_valid(mem_rdata_valid),
      .line(refill_line), .line_done(line_done)
   );

   line_merge u_line_merge (
      .src_line(src_line), .word_sel(word_sel),
      .wdata(wdata), .wmask(wmask), .we(we),
      .merged_line(merged_line), .sel_word(sel_word)
   );

endmodule

//--- tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
   import dcache_pkg::*;

   localparam int NUM_REQS       = 2000;
   localparam int RESET_CYCLES   = 10;
   localparam int TIMEOUT_CYCLES = NUM_REQS * 200 + RESET_CYCLES;
   localparam logic [31:0] SEED  = 32'h80e73ffe;

   logic                  clk;
   logic                  reset;
   logic                  ce;
   logic                  we;
   logic [ADDR_BITS-1:0]  addr;
   logic [WORD_BITS-1:0]  wdata;
   logic [WORD_BYTES-1:0] wmask;
   logic [WORD_BITS-1:0]  rdata;
   logic                  rdata_valid;
   logic                  write_resp;
   logic                  resp_ready;
   logic                  mem_ce;
   logic                  mem_we;
   logic [ADDR_BITS-1:0]  mem_addr;
   cache_line_t           mem_wdata;
   logic [WORD_BITS-1:0]  mem_rdata = '0;
   logic                  mem_rdata_valid = 1'b0;
   logic                  mem_write_resp = 1'b0;

   // backing memory seen by the cache and golden memory seen by the processor
   logic [WORD_BITS-1:0] backing [int unsigned];
   logic [7:0]           gold_mem [int unsigned];
   logic [31:0]          fill_seed;

   // residency model
   logic [TAG_BITS-1:0]   tag_m [NUM_SETS][NUM_WAYS];
   logic                  valid_m [NUM_SETS][NUM_WAYS];
   logic                  dirty_m [NUM_SETS][NUM_WAYS];
   logic                  lru_m [NUM_SETS];
   logic [TAG_BITS-1:0]   tag_pool [4];
   logic [INDEX_BITS-1:0] set_pool [3];

   // memory side bookkeeping
   int                   refill_count = 0;
   int                   wb_count = 0;
   int                   wb_at_refill = 0;
   logic [ADDR_BITS-1:0] last_refill_addr = '0;
   logic [ADDR_BITS-1:0] last_wb_addr = '0;
   int                   cycle_count = 0;

   dcache_top uut (
      .clk(clk), .reset(reset),
      .ce(ce), .we(we), .addr(addr), .wdata(wdata), .wmask(wmask),
      .rdata(rdata), .rdata_valid(rdata_valid), .write_resp(write_resp),
      .resp_ready(resp_ready),
      .mem_ce(mem_ce), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_rdata(mem_rdata), .mem_rdata_valid(mem_rdata_valid),
      .mem_write_resp(mem_write_resp)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_word(input string what, input logic [WORD_BITS-1:0] got,
                             input logic [WORD_BITS-1:0] exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("[ERROR] %0t: %s: got %h, expected %h",
                                     $time, what, got, exp));
      end
   endtask

   task automatic check_line(input string what, input cache_line_t got,
                             input cache_line_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("[ERROR] %0t: %s: got %h, expected %h",
                                     $time, what, got.flat, exp.flat));
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("[ERROR] %0t: %s: got %b, expected %b",
                                     $time, what, got, exp));
      end
   endtask

   // odd multiplier spreads every address bit
   function automatic logic [WORD_BITS-1:0] init_word(input int unsigned waddr);
      return (waddr * 32'h9e3779b1) ^ fill_seed;
   endfunction

   function automatic logic [WORD_BITS-1:0] memory_word(input int unsigned waddr);
      if (backing.exists(waddr)) begin
         return backing[waddr];
      end
      return init_word(waddr);
   endfunction

   function automatic logic [WORD_BITS-1:0] golden_word(input logic [ADDR_BITS-1:0] byte_addr);
      logic [WORD_BITS-1:0] w;
      int unsigned          base;
      base = byte_addr & ~32'h3;
      w = init_word(base >> 2);
      for (int b = 0; b < WORD_BYTES; b++) begin
         if (gold_mem.exists(base + b)) begin
            w[b*8 +: 8] = gold_mem[base + b];
         end
      end
      return w;
   endfunction

   function automatic cache_line_t golden_line(input logic [ADDR_BITS-1:0] line_addr);
      cache_line_t l;
      for (int i = 0; i < LINE_WORDS; i++) begin
         l.words[i] = golden_word(line_addr + ADDR_BITS'(i * WORD_BYTES));
      end
      return l;
   endfunction

   // memory model with random refill gaps and write-back delays
   int                   wb_wait;
   logic                 wb_active = 1'b0;
   logic                 rf_active = 1'b0;
   int unsigned          rf_words;
   logic [ADDR_BITS-1:0] rf_addr;

   always @(posedge clk) begin
      mem_rdata_valid <= 1'b0;
      mem_write_resp <= 1'b0;
      if (reset) begin
         wb_active = 1'b0;
         rf_active = 1'b0;
      end else if (mem_ce && mem_we) begin
         if (!wb_active && !mem_write_resp) begin
            wb_active = 1'b1;
            wb_wait = $urandom_range(0, 6);
            wb_count++;
            last_wb_addr = mem_addr;
            check_flag("write-back address aligned", mem_addr[OFFSET_BITS-1:0] == '0, 1'b1);
            check_line("write-back line", mem_wdata, golden_line(mem_addr));
         end else if (wb_active) begin
            if (wb_wait == 0) begin
               for (int i = 0; i < LINE_WORDS; i++) begin
                  backing[(mem_addr >> 2) + i] = mem_wdata.words[i];
               end
               wb_active = 1'b0;
               mem_write_resp <= 1'b1;
            end else begin
               wb_wait--;
            end
         end
      end else if (mem_ce) begin
         if (!rf_active) begin
            rf_active = 1'b1;
            rf_addr = mem_addr;
            rf_words = 0;
            refill_count++;
            wb_at_refill = wb_count;
            last_refill_addr = mem_addr;
         end
         if (rf_words < LINE_WORDS && $urandom_range(0, 2) != 0) begin
            mem_rdata <= memory_word((rf_addr >> 2) + rf_words);
            mem_rdata_valid <= 1'b1;
            rf_words++;
         end
      end else begin
         rf_active = 1'b0;
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         stop_with_failure($sformatf("run timed out after %0d cycles", cycle_count));
      end
   end

   // one request from issue to the edge where its response is taken
   task automatic run_request();
      logic [ADDR_BITS-1:0]  a;
      logic [ADDR_BITS-1:0]  victim_addr;
      logic [INDEX_BITS-1:0] set_idx;
      logic [TAG_BITS-1:0]   tag;
      logic                  w;
      logic [WORD_BITS-1:0]  d;
      logic [WORD_BYTES-1:0] m;
      logic                  hit;
      logic                  exp_wb;
      logic                  held;
      logic                  seen;
      logic                  done;
      logic                  held_rv;
      logic                  held_wr;
      logic [WORD_BITS-1:0]  held_data;
      int                    way;
      int                    cycles;
      int                    base_rf;
      int                    base_wb;
      int unsigned           base;
      a = {tag_pool[$urandom_range(0, 3)], set_pool[$urandom_range(0, 2)],
           4'($urandom), 2'b00};
      w = 1'($urandom_range(0, 1));
      d = $urandom;
      m = WORD_BYTES'($urandom);
      set_idx = a[OFFSET_BITS +: INDEX_BITS];
      tag = a[ADDR_BITS-1 -: TAG_BITS];

      // predict hit or victim
      hit = 1'b0;
      way = lru_m[set_idx] ? 1 : 0;
      for (int i = 0; i < NUM_WAYS; i++) begin
         if (valid_m[set_idx][i] && tag_m[set_idx][i] == tag) begin
            hit = 1'b1;
            way = i;
         end
      end
      exp_wb = !hit && dirty_m[set_idx][way];
      victim_addr = {tag_m[set_idx][way], set_idx, {OFFSET_BITS{1'b0}}};

      ce <= 1'b1;
      we <= w;
      addr <= a;
      wdata <= d;
      wmask <= m;
      base_rf = refill_count;
      base_wb = wb_count;
      cycles = 0;
      held = 1'b0;
      seen = 1'b0;
      done = 1'b0;
      while (!done) begin
         @(posedge clk);
         cycles++;
         if (hit) begin
            check_flag("memory access on a resident line", mem_ce, 1'b0);
         end
         if (held) begin
            check_flag("held rdata_valid", rdata_valid, held_rv);
            check_flag("held write_resp", write_resp, held_wr);
            check_word("held rdata", rdata, held_data);
         end
         if (rdata_valid || write_resp) begin
            if (hit && !seen) begin
               check_flag("hit response one cycle after request", cycles == 2, 1'b1);
            end
            seen = 1'b1;
            check_flag("write response kind", write_resp, w);
            if (resp_ready) begin
               done = 1'b1;
            end else begin
               held = 1'b1;
               held_rv = rdata_valid;
               held_wr = write_resp;
               held_data = rdata;
            end
         end
         resp_ready <= ($urandom_range(0, 3) != 0);
      end

      if (!hit) begin
         check_flag("one refill per miss", refill_count == base_rf + 1, 1'b1);
         check_word("refill address", last_refill_addr, {a[ADDR_BITS-1:OFFSET_BITS],
                                                         {OFFSET_BITS{1'b0}}});
         check_flag("write-back before refill", wb_at_refill == base_wb + int'(exp_wb), 1'b1);
         check_flag("no write-back after refill", wb_count == wb_at_refill, 1'b1);
         if (exp_wb) begin
            check_word("write-back address", last_wb_addr, victim_addr);
         end
      end

      if (w) begin
         base = a & ~32'h3;
         for (int b = 0; b < WORD_BYTES; b++) begin
            if (m[b]) begin
               gold_mem[base + b] = d[b*8 +: 8];
            end
         end
      end else begin
         check_word("read data", rdata, golden_word(a));
      end

      if (!hit) begin
         tag_m[set_idx][way] = tag;
         valid_m[set_idx][way] = 1'b1;
         dirty_m[set_idx][way] = w;
      end else if (w) begin
         dirty_m[set_idx][way] = 1'b1;
      end
      lru_m[set_idx] = (way == 0);
   endtask

   initial begin
      int gap;
      void'($urandom(SEED));
      fill_seed = $urandom;
      for (int i = 0; i < 4; i++) begin
         tag_pool[i] = TAG_BITS'($urandom);
      end
      set_pool[0] = 5'd0;
      set_pool[1] = 5'd13;
      set_pool[2] = 5'd31;
      for (int s = 0; s < NUM_SETS; s++) begin
         lru_m[s] = 1'b0;
         for (int w = 0; w < NUM_WAYS; w++) begin
            tag_m[s][w] = '0;
            valid_m[s][w] = 1'b0;
            dirty_m[s][w] = 1'b0;
         end
      end

      reset <= 1'b1;
      ce <= 1'b0;
      we <= 1'b0;
      addr <= '0;
      wdata <= '0;
      wmask <= '0;
      resp_ready <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;

      for (int n = 0; n < NUM_REQS; n++) begin
         run_request();
         gap = $urandom_range(0, 2);
         if (gap != 0) begin
            ce <= 1'b0;
            repeat (gap) @(posedge clk);
         end
      end
      ce <= 1'b0;
      repeat (4) @(posedge clk);
      $display("Verification passed");
      $finish;
   end

endmodule

//--- dcache_top.f
dcache_pkg.sv
tag_store.sv
data_store.sv
refill_buffer.sv
line_merge.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

//--- Makefile
SIM      = verilator
TOP      = tb_dcache
FILELIST = dcache_top.f
FLAGS    = --binary --timing --assert -j 0
BUILD    = obj_dir
LOG      = sim.log

SOURCES = $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
